//--- filelist.f
hdl/core_pkg.sv
hdl/rf_if.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/step_counter.sv
hdl/instr_ctrl.sv
hdl/core_top.sv
verif/core_sva.sv
verif/tb_core.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_core -f filelist.f -o tb_core_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^ALL CHECKS PASSED$" "$LOG"; then
	echo "Result: pass"
	exit 0
else
	echo "Result: fail"
	exit 1
fi

//--- verif/tb_core.sv
`timescale 1ns/1ns

module tb_core import core_pkg::*; ();

	localparam int CLK_PERIOD  = 10;
	localparam int DATA_W      = 16;
	localparam int NUM_RANDOM  = 300;
	localparam int MUL_LATENCY = DATA_W + 1;
	localparam int WAIT_LIMIT  = 4 * MUL_LATENCY;
	// Room for the prologue plus the slowest instruction for every operation
	localparam int WATCHDOG_CYCLES = (NUM_RANDOM + 100) * 20;

	logic              clk;
	logic              rst_n;
	logic              instr_valid;
	logic [15:0]       instr;
	logic              busy;
	logic              done;
	logic              wb_en;
	logic [2:0]        wb_sel;
	logic [DATA_W-1:0] wb_data;

	logic [DATA_W-1:0] model [8];
	integer            seed;
	int                errors;
	int                checks;
	int                issued;
	int                done_seen;

	core_top #(.DATA_W(DATA_W)) i_core_top (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.busy        (busy),
		.done        (done),
		.wb_en       (wb_en),
		.wb_sel      (wb_sel),
		.wb_data     (wb_data)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// Count every done pulse to catch extra completions
	always @(negedge clk) begin
		if (rst_n && done) begin
			done_seen++;
		end
	end

	task automatic check_value(input string name, input logic [DATA_W-1:0] exp_val,
			input logic [DATA_W-1:0] act_val);
		checks++;
		assert (act_val === exp_val) else begin
			errors++;
			$display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp_val, act_val);
		end
	endtask

	// Expected write-back value from the register model
	function automatic logic [DATA_W-1:0] model_result(input logic [15:0] w);
		logic [3:0]        op;
		logic [DATA_W-1:0] a;
		logic [DATA_W-1:0] b;
		logic [DATA_W-1:0] simm;
		op   = w[15:12];
		a    = model[w[8:6]];
		b    = model[w[5:3]];
		simm = {{(DATA_W-6){w[5]}}, w[5:0]};
		case (op)
			OP_ADD:  return a + b;
			OP_SUB:  return a - b;
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_MUL:  return a * b;
			OP_ADDI: return a + simm;
			OP_LDI:  return simm;
			default: return '0;
		endcase
	endfunction

	task automatic run_instr(input logic [15:0] w);
		logic [DATA_W-1:0] exp_data;
		logic              expect_wr;
		int                latency;
		int                cycles;
		exp_data  = model_result(w);
		expect_wr = (w[15:12] <= 4'h7);
		latency   = (w[15:12] == OP_MUL) ? MUL_LATENCY : 1;
		check_value("busy", 1'b0, busy);
		instr_valid = 1'b1;
		instr       = w;
		issued++;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
			check_value("busy", 1'b1, busy);
			// Stray strobes while busy must be dropped
			instr_valid = (($random(seed) & 3) == 0) && !done;
			instr       = 16'($random(seed));
		end while (!done && cycles < WAIT_LIMIT);
		if (!done) begin
			errors++;
			$display("No done within %0d cycles of accepting instruction %h", cycles, w);
		end else begin
			check_value("done latency", 16'(latency), 16'(cycles));
			check_value("wb_en", expect_wr, wb_en);
			if (expect_wr && wb_en) begin
				check_value("wb_sel", w[11:9], wb_sel);
				check_value("wb_data", exp_data, wb_data);
				model[w[11:9]] = exp_data;
			end
		end
		@(negedge clk);
		instr_valid = 1'b0;
		check_value("busy", 1'b0, busy);
		check_value("done", 1'b0, done);
		check_value("wb_en", 1'b0, wb_en);
	endtask

	initial begin
		logic [3:0]  op;
		logic [15:0] w;
		seed        = 32'h0170_553e;
		errors      = 0;
		checks      = 0;
		issued      = 0;
		done_seen   = 0;
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		for (int i = 0; i < 8; i++) begin
			model[i] = '0;
		end
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("busy", 1'b0, busy);
		check_value("done", 1'b0, done);
		check_value("wb_en", 1'b0, wb_en);

		// Each register doubled into its neighbour reads zero after reset
		for (int r = 0; r < 8; r++) begin
			run_instr({OP_ADD, 3'(r + 1), 3'(r), 3'(r), 3'b000});
		end

		// Immediates of both signs
		run_instr({OP_LDI, 3'd1, 3'd0, 6'h3b});
		run_instr({OP_LDI, 3'd2, 3'd5, 6'h17});
		run_instr({OP_LDI, 3'd3, 3'd0, 6'h20});
		run_instr({OP_ADDI, 3'd4, 3'd1, 6'h3f});
		run_instr({OP_ADDI, 3'd5, 3'd2, 6'h1f});

		// Every single-cycle register operation and multiply
		for (int k = 0; k < 5; k++) begin
			run_instr({4'(k), 3'd6, 3'd1, 3'd2, 3'b000});
		end
		run_instr({OP_MUL, 3'd7, 3'd1, 3'd3, 3'b000});
		run_instr({OP_MUL, 3'd6, 3'd2, 3'd5, 3'b000});
		run_instr({4'h8, 12'h123});
		run_instr({4'hf, 12'hfff});

		for (int n = 0; n < NUM_RANDOM; n++) begin
			op = 4'($unsigned($random(seed)) % 10);
			w  = {op, 12'($random(seed))};
			run_instr(w);
		end

		repeat (4) @(negedge clk);
		check_value("done count", 16'(issued), 16'(done_seen));
		// Bound protocol properties count toward the total
		errors += i_core_top.i_core_sva.fail_count;
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles before the tests finished",
			WATCHDOG_CYCLES);
		$display("Summary: %0d checks, %0d errors", checks,
			errors + i_core_top.i_core_sva.fail_count);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- verif/core_sva.sv
`timescale 1ns/1ns

module core_sva (
	input logic clk,
	input logic rst_n,
	input logic busy,
	input logic done,
	input logic wb_en
);

	// Failures seen by the properties below
	int fail_count = 0;

	// Completion and write-back are one-cycle pulses
	done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
		else begin
			fail_count++;
			$error("done stayed high for more than one cycle");
		end

	wb_en_pulse: assert property (@(posedge clk) disable iff (!rst_n) wb_en |=> !wb_en)
		else begin
			fail_count++;
			$error("wb_en stayed high for more than one cycle");
		end

	wb_en_done: assert property (@(posedge clk) disable iff (!rst_n) wb_en |-> done)
		else begin
			fail_count++;
			$error("wb_en raised without done");
		end

	done_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
		else begin
			fail_count++;
			$error("done raised while busy was low");
		end

	// Idle right after reset release
	reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> !busy && !done && !wb_en)
		else begin
			fail_count++;
			$error("core not idle when reset was released");
		end

endmodule

bind core_top core_sva i_core_sva (
	.clk   (clk),
	.rst_n (rst_n),
	.busy  (busy),
	.done  (done),
	.wb_en (wb_en)
);

//--- hdl/core_top.sv
`timescale 1ns/1ns

module core_top import core_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               instr_valid,
	input  logic [INSTR_W-1:0] instr,
	output logic               busy,
	output logic               done,
	output logic               wb_en,
	output logic [SEL_W-1:0]   wb_sel,
	output logic [DATA_W-1:0]  wb_data
);

	// Enough bits to count DATA_W multiply steps
	localparam int COUNT_W = $clog2(DATA_W);

	alu_op_e           alu_op;
	logic [5:0]        imm;
	logic              imm_sel;
	logic              mul_start;
	logic              mul_step;
	logic              cnt_load;
	logic              cnt_run;
	logic              last;
	logic [DATA_W-1:0] alu_result;

	rf_if #(.DATA_W(DATA_W)) rf ();

	instr_ctrl i_instr_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (instr_valid),
		.instr       (instr),
		.last        (last),
		.busy        (busy),
		.done        (done),
		.mul_start   (mul_start),
		.mul_step    (mul_step),
		.cnt_load    (cnt_load),
		.cnt_run     (cnt_run),
		.alu_op      (alu_op),
		.imm         (imm),
		.imm_sel     (imm_sel),
		.rf          (rf)
	);

	step_counter #(.COUNT_W(COUNT_W)) i_step_counter (
		.clk   (clk),
		.rst_n (rst_n),
		.load  (cnt_load),
		.run   (cnt_run),
		.last  (last)
	);

	alu #(.DATA_W(DATA_W)) i_alu (
		.clk       (clk),
		.rst_n     (rst_n),
		.op        (alu_op),
		.a         (rf.read1_out),
		.b         (rf.read2_out),
		.imm       (imm),
		.imm_sel   (imm_sel),
		.mul_start (mul_start),
		.mul_step  (mul_step),
		.result    (alu_result)
	);

	reg_file #(.DATA_W(DATA_W)) i_reg_file (
		.clk   (clk),
		.rst_n (rst_n),
		.rf    (rf)
	);

	// Write-back port mirrors the register file write
	assign rf.write_data = alu_result;
	assign wb_data       = alu_result;
	assign wb_sel        = rf.write1_sel;
	assign wb_en         = rf.write_en;

endmodule

//--- hdl/instr_ctrl.sv
`timescale 1ns/1ns

module instr_ctrl import core_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       instr_valid,
	input  instr_u     instr,
	input  logic       last,
	output logic       busy,
	output logic       done,
	output logic       mul_start,
	output logic       mul_step,
	output logic       cnt_load,
	output logic       cnt_run,
	output alu_op_e    alu_op,
	output logic [5:0] imm,
	output logic       imm_sel,
	rf_if.ctrl         rf
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_EXEC = 2'd1;
	localparam logic [1:0] ST_MUL  = 2'd2;

	logic [1:0] state;
	logic       accept;
	logic       is_itype;
	logic       wr_op;
	instr_u     instr_q;
	instr_u     cur;

	assign accept = instr_valid && (state == ST_IDLE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (instr_valid) begin
						state <= (instr.r.opcode == OP_MUL) ? ST_MUL : ST_EXEC;
					end
				end
				ST_MUL: begin
					if (last) begin
						state <= ST_EXEC;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			instr_q <= instr;
		end
	end

	// In idle the incoming word addresses the read ports,
	// so multiply operands are ready at the acceptance edge
	assign cur = (state == ST_IDLE) ? instr : instr_q;

	// Register selects from the view matching the opcode
	always_comb begin
		is_itype = (cur.i.opcode == OP_ADDI) || (cur.i.opcode == OP_LDI);
		if (is_itype) begin
			rf.read1_sel  = cur.i.rs1;
			rf.read2_sel  = cur.i.rs1;
			rf.write1_sel = cur.i.rd;
		end else begin
			rf.read1_sel  = cur.r.rs1;
			rf.read2_sel  = cur.r.rs2;
			rf.write1_sel = cur.r.rd;
		end
	end

	// ALU operation for the held instruction
	always_comb begin
		alu_op  = ALU_ADD;
		imm_sel = 1'b0;
		wr_op   = 1'b1;
		case (instr_q.r.opcode)
			OP_ADD: alu_op = ALU_ADD;
			OP_SUB: alu_op = ALU_SUB;
			OP_AND: alu_op = ALU_AND;
			OP_OR:  alu_op = ALU_OR;
			OP_XOR: alu_op = ALU_XOR;
			OP_MUL: alu_op = ALU_PASSB;
			OP_ADDI: begin
				alu_op  = ALU_ADD;
				imm_sel = 1'b1;
			end
			OP_LDI: begin
				alu_op  = ALU_PASSB;
				imm_sel = 1'b1;
			end
			default: wr_op = 1'b0;
		endcase
	end

	assign imm         = instr_q.i.imm6;
	assign rf.write_en = (state == ST_EXEC) && wr_op;

	assign busy      = (state != ST_IDLE);
	assign done      = (state == ST_EXEC);
	assign mul_start = accept && (instr.r.opcode == OP_MUL);
	assign cnt_load  = mul_start;
	assign mul_step  = (state == ST_MUL);
	assign cnt_run   = mul_step;

endmodule

//--- hdl/step_counter.sv
`timescale 1ns/1ns

module step_counter #(
	parameter int COUNT_W = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic load,
	input  logic run,
	output logic last
);

	logic [COUNT_W-1:0] count;

	// All ones is DATA_W - 1 for a power-of-two data width
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (load) begin
			count <= '1;
		end else if (run && (count != '0)) begin
			count <= count - 1'b1;
		end
	end

	// Final step seen while still running
	assign last = run && (count == '0);

endmodule

//--- hdl/alu.sv
`timescale 1ns/1ns

module alu import core_pkg::*; #(
	parameter int DATA_W = 16
) (
	input  logic              clk,
	input  logic              rst_n,
	input  alu_op_e           op,
	input  logic [DATA_W-1:0] a,
	input  logic [DATA_W-1:0] b,
	input  logic [5:0]        imm,
	input  logic              imm_sel,
	input  logic              mul_start,
	input  logic              mul_step,
	output logic [DATA_W-1:0] result
);

	logic [DATA_W-1:0] imm_ext;
	logic [DATA_W-1:0] opnd_b;
	logic [DATA_W-1:0] mcand;
	logic [DATA_W-1:0] mplier;
	logic [DATA_W-1:0] product;

	assign imm_ext = {{(DATA_W-6){imm[5]}}, imm};
	assign opnd_b  = imm_sel ? imm_ext : b;

	// Shift-and-add multiply, one multiplier bit per step
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mcand   <= '0;
			mplier  <= '0;
			product <= '0;
		end else if (mul_start) begin
			mcand   <= a;
			mplier  <= b;
			product <= '0;
		end else if (mul_step) begin
			if (mplier[0]) begin
				product <= product + mcand;
			end
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	always_comb begin
		case (op)
			ALU_ADD: result = a + opnd_b;
			ALU_SUB: result = a - opnd_b;
			ALU_AND: result = a & opnd_b;
			ALU_OR:  result = a | opnd_b;
			ALU_XOR: result = a ^ opnd_b;
			// Immediate for LDI, otherwise the finished product
			ALU_PASSB: result = imm_sel ? imm_ext : product;
			default: result = '0;
		endcase
	end

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ns

module reg_file import core_pkg::*; #(
	parameter int DATA_W = 16
) (
	input logic clk,
	input logic rst_n,
	rf_if.regs  rf
);

	localparam int NUM_REGS = 2 ** SEL_W;

	logic [DATA_W-1:0] regs [NUM_REGS];

	// One enabled register per entry, write picked by index
	genvar g;
	generate
		for (g = 0; g < NUM_REGS; g++) begin : g_reg
			logic hit;

			assign hit = rf.write_en && (rf.write1_sel == SEL_W'(g));

			always_ff @(posedge clk or negedge rst_n) begin
				if (!rst_n) begin
					regs[g] <= '0;
				end else if (hit) begin
					regs[g] <= rf.write_data;
				end
			end
		end
	endgenerate

	// Two independent read ports
	assign rf.read1_out = regs[rf.read1_sel];
	assign rf.read2_out = regs[rf.read2_sel];

endmodule

//--- hdl/rf_if.sv
`timescale 1ns/1ns

interface rf_if import core_pkg::*; #(
	parameter int DATA_W = 16
) ();

	// Read side
	logic [SEL_W-1:0]  read1_sel;
	logic [SEL_W-1:0]  read2_sel;
	logic [DATA_W-1:0] read1_out;
	logic [DATA_W-1:0] read2_out;

	// Write side
	logic [SEL_W-1:0]  write1_sel;
	logic              write_en;
	logic [DATA_W-1:0] write_data;

	modport regs (
		input  read1_sel, read2_sel,
		input  write1_sel, write_en, write_data,
		output read1_out, read2_out
	);

	// Write data is tied to the ALU result at the top level
	modport ctrl (
		output read1_sel, read2_sel,
		output write1_sel, write_en
	);

endinterface

//--- hdl/core_pkg.sv
package core_pkg;

	// Instruction word and register select widths
	localparam int INSTR_W = 16;
	localparam int SEL_W   = 3;

	// Opcodes; codes above OP_LDI are no-ops
	typedef enum logic [3:0] {
		OP_ADD  = 4'h0,
		OP_SUB  = 4'h1,
		OP_AND  = 4'h2,
		OP_OR   = 4'h3,
		OP_XOR  = 4'h4,
		OP_MUL  = 4'h5,
		OP_ADDI = 4'h6,
		OP_LDI  = 4'h7
	} opcode_e;

	typedef enum logic [2:0] {
		ALU_ADD   = 3'd0,
		ALU_SUB   = 3'd1,
		ALU_AND   = 3'd2,
		ALU_OR    = 3'd3,
		ALU_XOR   = 3'd4,
		ALU_PASSB = 3'd5
	} alu_op_e;

	// Register-register form
	typedef struct packed {
		opcode_e          opcode;
		logic [SEL_W-1:0] rd;
		logic [SEL_W-1:0] rs1;
		logic [SEL_W-1:0] rs2;
		logic [2:0]       unused;
	} instr_r_t;

	// Immediate form
	typedef struct packed {
		opcode_e          opcode;
		logic [SEL_W-1:0] rd;
		logic [SEL_W-1:0] rs1;
		logic signed [5:0] imm6;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage
